// File: logic/lsu_pkg.sv
package lsu_pkg;

   localparam int XLEN   = 32; // data path width.
   localparam int CNT_W  = 5;  // bit counter, one pass over XLEN bits.
   localparam int ADDR_W = 32; // byte address width.

   // memory operation requested on the command port.
   typedef enum logic {
      LSU_LOAD,
      LSU_STORE
   } lsu_op_e;

   // access width, encoded as in funct3[1:0].
   typedef enum logic [1:0] {
      SZ_BYTE,
      SZ_HALF,
      SZ_WORD
   } lsu_size_e;

   typedef enum logic [2:0] {
      ST_IDLE,   // waiting for a command.
      ST_INIT,   // store data shifted into place, alignment checked.
      ST_BUS,    // memory transaction running.
      ST_RESULT, // load bits shifted out into the result.
      ST_DONE    // ack held until the requester lets go.
   } lsu_state_e;

endpackage

// File: logic/lsu_serial_if.sv
`timescale 1ns/100ps

// bit-serial link from the sequencer to the data shifter.
interface lsu_serial_if;

   logic                en;        // shift enable, one bit per cycle.
   logic                init;      // high for the 32 init cycles.
   logic                cnt_done;  // last bit of the pass.
   logic [1:0]          bytecnt;   // byte currently on the serial line.
   logic [1:0]          lsb;       // low address bits of the access.
   lsu_pkg::lsu_size_e  size;
   logic                is_signed; // sign extend loads.
   logic                op_b;      // serial store bit, lsb first.
   logic                rd;        // serial load bit, lsb first.

   modport seq (
      output en,
      output init,
      output cnt_done,
      output bytecnt,
      output lsb,
      output size,
      output is_signed,
      output op_b,
      input  rd
   );

   modport shift (
      input  en,
      input  init,
      input  cnt_done,
      input  bytecnt,
      input  lsb,
      input  size,
      input  is_signed,
      input  op_b,
      output rd
   );

endinterface

// File: logic/lsu_sequencer.sv
`timescale 1ns/100ps

module lsu_sequencer (
   input  logic                       i_clk,
   input  logic                       i_arst_n,
   input  logic                       i_cmd_req,
   input  lsu_pkg::lsu_op_e           i_cmd_op,
   input  lsu_pkg::lsu_size_e         i_cmd_size,
   input  logic                       i_cmd_signed,
   input  logic [lsu_pkg::ADDR_W-1:0] i_cmd_addr,
   input  logic [lsu_pkg::XLEN-1:0]   i_cmd_wdata,
   input  logic                       i_bus_done,
   output logic                       o_cmd_ack,
   output logic [lsu_pkg::XLEN-1:0]   o_rsp_data,
   output logic                       o_rsp_misalign,
   output logic                       o_bus_start,
   lsu_serial_if.seq                  sif
);

   lsu_pkg::lsu_state_e         state_q;
   lsu_pkg::lsu_state_e         state_d;
   logic [lsu_pkg::CNT_W-1:0]   cnt_q;         // bit position of the current pass.
   logic                        misalign_c;
   logic                        misalign_q;
   logic                        bus_start_q;
   logic [lsu_pkg::XLEN-1:0]    rsp_q;         // result word, filled from the top.
   logic                        start_cmd;     // new command accepted this cycle.
   logic                        is_load;

   assign is_load   = (i_cmd_op == lsu_pkg::LSU_LOAD);
   assign start_cmd = (state_q == lsu_pkg::ST_IDLE) & i_cmd_req;

   // command fields go straight onto the serial link.
   assign sif.lsb       = i_cmd_addr[1:0];
   assign sif.size      = i_cmd_size;
   assign sif.is_signed = i_cmd_signed;

   // counter decode.
   assign sif.bytecnt  = cnt_q[lsu_pkg::CNT_W-1 -: 2]; // upper two bits pick the byte.
   assign sif.cnt_done = &cnt_q;
   assign sif.init     = (state_q == lsu_pkg::ST_INIT);
   assign sif.en       = sif.init | (state_q == lsu_pkg::ST_RESULT);
   assign sif.op_b     = sif.init & i_cmd_wdata[cnt_q]; // store word, lsb first.

   // half needs an even address, word needs both low bits clear.
   assign misalign_c =
      (i_cmd_addr[0] & (i_cmd_size != lsu_pkg::SZ_BYTE)) |
      (i_cmd_addr[1] & (i_cmd_size == lsu_pkg::SZ_WORD));

   always_comb begin
      state_d = state_q;
      case (state_q)
         lsu_pkg::ST_IDLE:   if (i_cmd_req) state_d = lsu_pkg::ST_INIT;
         lsu_pkg::ST_INIT: begin
            if (sif.cnt_done) begin
               state_d = misalign_c ? lsu_pkg::ST_DONE : lsu_pkg::ST_BUS; // no bus on a trap.
            end
         end
         lsu_pkg::ST_BUS: begin
            if (i_bus_done) begin
               state_d = is_load ? lsu_pkg::ST_RESULT : lsu_pkg::ST_DONE;
            end
         end
         lsu_pkg::ST_RESULT: if (sif.cnt_done) state_d = lsu_pkg::ST_DONE;
         lsu_pkg::ST_DONE:   if (!i_cmd_req) state_d = lsu_pkg::ST_IDLE; // four-phase release.
         default:            state_d = lsu_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q     <= lsu_pkg::ST_IDLE;
         cnt_q       <= '0;
         misalign_q  <= 1'b0;
         bus_start_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         // counter only moves while bits are on the line, wraps to zero after 32.
         if (state_q == lsu_pkg::ST_IDLE) begin
            cnt_q <= '0;
         end else if (sif.en) begin
            cnt_q <= cnt_q + 1'b1;
         end
         if (start_cmd) begin
            misalign_q <= 1'b0;
         end else if (sif.init && sif.cnt_done) begin
            misalign_q <= misalign_c; // sampled once, after the address settled.
         end
         bus_start_q <= sif.init & sif.cnt_done & ~misalign_c; // one cycle pulse.
      end
   end

   // result reassembly, one bit per cycle into the top.
   always_ff @(posedge i_clk) begin
      if (start_cmd) begin
         rsp_q <= '0;                           // stores and traps return zero.
      end else if (state_q == lsu_pkg::ST_RESULT) begin
         rsp_q <= {sif.rd, rsp_q[lsu_pkg::XLEN-1:1]};
      end
   end

   assign o_cmd_ack      = (state_q == lsu_pkg::ST_DONE);
   assign o_rsp_data     = rsp_q;
   assign o_rsp_misalign = misalign_q;
   assign o_bus_start    = bus_start_q;

   // a trapped access must never reach the memory port.
   a_no_bus_on_misalign : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      o_bus_start |->
         (i_cmd_size == lsu_pkg::SZ_BYTE) ||
         (i_cmd_size == lsu_pkg::SZ_HALF && !i_cmd_addr[0]) ||
         (i_cmd_size == lsu_pkg::SZ_WORD && i_cmd_addr[1:0] == 2'b00)
   );

   // requester keeps the command stable for the whole handshake.
   a_cmd_stable : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      (i_cmd_req && $past(i_cmd_req)) |->
         $stable({i_cmd_op, i_cmd_size, i_cmd_signed, i_cmd_addr, i_cmd_wdata})
   );

endmodule

// File: logic/lsu_data_shifter.sv
`timescale 1ns/100ps

module lsu_data_shifter (
   input  logic                     i_clk,
   input  logic                     i_rdat_load,
   input  logic [lsu_pkg::XLEN-1:0] i_rdat,
   output logic [lsu_pkg::XLEN-1:0] o_wdat,
   output logic [3:0]               o_sel,
   lsu_serial_if.shift              sif
);

   logic [lsu_pkg::XLEN-1:0] dat_q;      // store word or latched load word.
   logic                     signbit_q;  // last valid load bit, repeated past the width.
   logic [2:0]               lane_sum;
   logic                     byte_valid;
   logic                     dat_en;
   logic                     dat_cur;
   logic                     dat_valid;
   logic                     is_word;
   logic                     is_half;

   assign is_word = (sif.size == lsu_pkg::SZ_WORD);
   assign is_half = (sif.size == lsu_pkg::SZ_HALF);

   // shift only while lsb + bytecnt stays inside the word.
   // a store at lane n thus stops early and lands n bytes up.
   assign lane_sum   = {1'b0, sif.lsb} + {1'b0, sif.bytecnt};
   assign byte_valid = ~lane_sum[2];
   assign dat_en     = sif.en & byte_valid;

   // current load bit sits at the bottom of lane lsb.
   assign dat_cur = dat_q[{sif.lsb, 3'b000}];

   // bytes inside the access width.
   assign dat_valid = is_word | (sif.bytecnt == 2'b00) | (is_half & ~sif.bytecnt[1]);

   // past the access width repeat the sign, or zero for unsigned loads.
   assign sif.rd = dat_valid ? dat_cur : (signbit_q & sif.is_signed);

   always_ff @(posedge i_clk) begin
      if (i_rdat_load) begin
         dat_q <= i_rdat;                               // read word from the bus.
      end else if (dat_en) begin
         dat_q <= {sif.op_b, dat_q[lsu_pkg::XLEN-1:1]}; // store in at top, load out at lane.
      end
      if (sif.en && dat_valid) begin
         signbit_q <= dat_cur;
      end
   end

   // lane selects.
   assign o_sel[3] = (sif.lsb == 2'd3) | is_word | (is_half & sif.lsb[1]);
   assign o_sel[2] = (sif.lsb == 2'd2) | is_word;
   assign o_sel[1] = (sif.lsb == 2'd1) | is_word | (is_half & ~sif.lsb[1]);
   assign o_sel[0] = (sif.lsb == 2'd0);

   assign o_wdat = dat_q;

   // read data arrives only after the store shift is over.
   a_no_load_in_init : assert property (
      @(posedge i_clk) i_rdat_load |-> !sif.init
   );

endmodule

// File: logic/lsu_bus_master.sv
`timescale 1ns/100ps

module lsu_bus_master (
   input  logic                       i_clk,
   input  logic                       i_arst_n,
   input  logic                       i_bus_start,
   input  logic                       i_we,
   input  logic [lsu_pkg::ADDR_W-1:0] i_addr,
   input  logic [3:0]                 i_sel,
   input  logic [lsu_pkg::XLEN-1:0]   i_wdat,
   input  logic                       i_mem_ack,
   input  logic [lsu_pkg::XLEN-1:0]   i_mem_rdat,
   output logic                       o_bus_done,
   output logic                       o_mem_req,
   output logic                       o_mem_we,
   output logic [lsu_pkg::ADDR_W-1:0] o_mem_addr,
   output logic [3:0]                 o_mem_sel,
   output logic [lsu_pkg::XLEN-1:0]   o_mem_wdat,
   output logic                       o_rdat_load,
   output logic [lsu_pkg::XLEN-1:0]   o_rdat
);

   // handshake phases, local to this block.
   typedef enum logic [1:0] {
      BM_IDLE,      // no transaction.
      BM_WAIT_ACK,  // req high, waiting for ack.
      BM_WAIT_DROP  // req dropped, waiting for ack to fall.
   } bm_state_e;

   bm_state_e                 state_q;
   logic                      req_q;
   logic                      done_q;
   logic                      we_q;
   logic [lsu_pkg::ADDR_W-1:0] addr_q;
   logic [3:0]                sel_q;
   logic [lsu_pkg::XLEN-1:0]  wdat_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= BM_IDLE;
         req_q   <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            BM_IDLE: begin
               if (i_bus_start) begin
                  req_q   <= 1'b1;
                  state_q <= BM_WAIT_ACK;
               end
            end
            BM_WAIT_ACK: begin
               if (i_mem_ack) begin
                  req_q   <= 1'b0;
                  state_q <= BM_WAIT_DROP;
               end
            end
            BM_WAIT_DROP: begin
               if (!i_mem_ack) begin
                  done_q  <= 1'b1; // done one cycle after ack seen low.
                  state_q <= BM_IDLE;
               end
            end
            default: state_q <= BM_IDLE;
         endcase
      end
   end

   // transaction fields, held while req is up.
   always_ff @(posedge i_clk) begin
      if ((state_q == BM_IDLE) && i_bus_start) begin
         we_q   <= i_we;
         addr_q <= {i_addr[lsu_pkg::ADDR_W-1:2], 2'b00}; // word aligned.
         sel_q  <= i_sel;
         wdat_q <= i_wdat;
      end
   end

   assign o_mem_req  = req_q;
   assign o_mem_we   = we_q;
   assign o_mem_addr = addr_q;
   assign o_mem_sel  = sel_q;
   assign o_mem_wdat = wdat_q;
   assign o_bus_done = done_q;

   // read word handed over in the first ack cycle.
   assign o_rdat_load = (state_q == BM_WAIT_ACK) & i_mem_ack & ~we_q;
   assign o_rdat      = i_mem_rdat;

   // four-phase order: previous ack must be gone before a new req.
   a_req_after_ack_low : assert property (
      @(posedge i_clk) disable iff (!i_arst_n)
      $rose(o_mem_req) |-> !i_mem_ack
   );

endmodule

// File: logic/serial_lsu_top.sv
`timescale 1ns/100ps

module serial_lsu_top (
   input  logic                       i_clk,
   input  logic                       i_arst_n,
   // command side.
   input  logic                       i_cmd_req,
   input  lsu_pkg::lsu_op_e           i_cmd_op,
   input  lsu_pkg::lsu_size_e         i_cmd_size,
   input  logic                       i_cmd_signed,
   input  logic [lsu_pkg::ADDR_W-1:0] i_cmd_addr,
   input  logic [lsu_pkg::XLEN-1:0]   i_cmd_wdata,
   output logic                       o_cmd_ack,
   output logic [lsu_pkg::XLEN-1:0]   o_rsp_data,
   output logic                       o_rsp_misalign,
   // memory side.
   output logic                       o_mem_req,
   output logic                       o_mem_we,
   output logic [lsu_pkg::ADDR_W-1:0] o_mem_addr,
   output logic [3:0]                 o_mem_sel,
   output logic [lsu_pkg::XLEN-1:0]   o_mem_wdat,
   input  logic                       i_mem_ack,
   input  logic [lsu_pkg::XLEN-1:0]   i_mem_rdat
);

   logic                     bus_start;
   logic                     bus_done;
   logic                     rdat_load;
   logic [lsu_pkg::XLEN-1:0] rdat;
   logic [lsu_pkg::XLEN-1:0] wdat;   // aligned store word.
   logic [3:0]               sel;
   logic                     is_store;

   assign is_store = (i_cmd_op == lsu_pkg::LSU_STORE);

   lsu_serial_if sif0 ();

   lsu_sequencer seq0 (
      .i_clk          (i_clk),
      .i_arst_n       (i_arst_n),
      .i_cmd_req      (i_cmd_req),
      .i_cmd_op       (i_cmd_op),
      .i_cmd_size     (i_cmd_size),
      .i_cmd_signed   (i_cmd_signed),
      .i_cmd_addr     (i_cmd_addr),
      .i_cmd_wdata    (i_cmd_wdata),
      .i_bus_done     (bus_done),
      .o_cmd_ack      (o_cmd_ack),
      .o_rsp_data     (o_rsp_data),
      .o_rsp_misalign (o_rsp_misalign),
      .o_bus_start    (bus_start),
      .sif            (sif0.seq)
   );

   lsu_data_shifter shift0 (
      .i_clk       (i_clk),
      .i_rdat_load (rdat_load),
      .i_rdat      (rdat),
      .o_wdat      (wdat),
      .o_sel       (sel),
      .sif         (sif0.shift)
   );

   lsu_bus_master bus0 (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_bus_start (bus_start),
      .i_we        (is_store),
      .i_addr      (i_cmd_addr),
      .i_sel       (sel),
      .i_wdat      (wdat),
      .i_mem_ack   (i_mem_ack),
      .i_mem_rdat  (i_mem_rdat),
      .o_bus_done  (bus_done),
      .o_mem_req   (o_mem_req),
      .o_mem_we    (o_mem_we),
      .o_mem_addr  (o_mem_addr),
      .o_mem_sel   (o_mem_sel),
      .o_mem_wdat  (o_mem_wdat),
      .o_rdat_load (rdat_load),
      .o_rdat      (rdat)
   );

endmodule

// File: bench/mem_model.sv
`timescale 1ns/100ps

// byte lane memory of 64 words behind a four-phase req/ack port.
module mem_model (
   input  logic        i_clk,
   input  logic        i_req,
   input  logic        i_we,
   input  logic [31:0] i_addr,
   input  logic [3:0]  i_sel,
   input  logic [31:0] i_wdat,
   output logic        o_ack,
   output logic [31:0] o_rdat
);

   logic [31:0] mem [0:63]; // little endian lanes, byte 0 in bits 7:0.
   logic [31:0] rand_q;     // delay generator state.
   logic [1:0]  delay;

   // lcg step, upper bits give 0 to 3 wait cycles.
   function automatic logic [1:0] draw_delay();
      rand_q = rand_q * 32'd1103515245 + 32'd12345;
      return rand_q[17:16];
   endfunction

   // start pattern over the full byte address.
   function automatic logic [7:0] fill_byte(logic [7:0] a);
      return a * 8'd37 + 8'd11;
   endfunction

   initial begin
      rand_q = 32'd80;
      o_ack  = 1'b0;
      o_rdat = '0;
      for (int i = 0; i < 64; i++) begin
         for (int b = 0; b < 4; b++) begin
            mem[i][8*b +: 8] = fill_byte(8'(i * 4 + b));
         end
      end
      forever begin
         @(negedge i_clk);
         if (i_req && !o_ack) begin
            delay = draw_delay();          // wait before ack rises.
            repeat (delay) @(negedge i_clk);
            @(posedge i_clk);
            if (i_we) begin
               for (int b = 0; b < 4; b++) begin
                  if (i_sel[b]) mem[i_addr[7:2]][8*b +: 8] = i_wdat[8*b +: 8];
               end
            end
            o_rdat <= mem[i_addr[7:2]];     // held while ack is high.
            o_ack  <= 1'b1;
         end else if (!i_req && o_ack) begin
            delay = draw_delay();          // wait before ack falls.
            repeat (delay) @(negedge i_clk);
            @(posedge i_clk);
            o_ack <= 1'b0;
         end
      end
   end

endmodule

// File: bench/tb_serial_lsu.sv
`timescale 1ns/100ps

module tb_serial_lsu;

   logic               i_clk;
   logic               i_arst_n;
   logic               cmd_req;
   lsu_pkg::lsu_op_e   cmd_op;
   lsu_pkg::lsu_size_e cmd_size;
   logic               cmd_signed;
   logic [31:0]        cmd_addr;
   logic [31:0]        cmd_wdata;
   logic               cmd_ack;
   logic [31:0]        rsp_data;
   logic               rsp_misalign;
   logic               mem_req;
   logic               mem_we;
   logic [31:0]        mem_addr;
   logic [3:0]         mem_sel;
   logic [31:0]        mem_wdat;
   logic               mem_ack;
   logic [31:0]        mem_rdat;

   logic [7:0]         shadow [0:255];      // reference image of mem0, per byte.
   logic [31:0]        rand_q        = 32'd80;
   logic               mem_req_seen  = 1'b0;
   int                 mem_req_rises = 0;   // memory transactions started.
   int                 value_errors  = 0;
   int                 proto_errors  = 0;
   int                 cycles        = 0;

   serial_lsu_top dut0 (
      .i_clk          (i_clk),
      .i_arst_n       (i_arst_n),
      .i_cmd_req      (cmd_req),
      .i_cmd_op       (cmd_op),
      .i_cmd_size     (cmd_size),
      .i_cmd_signed   (cmd_signed),
      .i_cmd_addr     (cmd_addr),
      .i_cmd_wdata    (cmd_wdata),
      .o_cmd_ack      (cmd_ack),
      .o_rsp_data     (rsp_data),
      .o_rsp_misalign (rsp_misalign),
      .o_mem_req      (mem_req),
      .o_mem_we       (mem_we),
      .o_mem_addr     (mem_addr),
      .o_mem_sel      (mem_sel),
      .o_mem_wdat     (mem_wdat),
      .i_mem_ack      (mem_ack),
      .i_mem_rdat     (mem_rdat)
   );

   mem_model mem0 (
      .i_clk  (i_clk),
      .i_req  (mem_req),
      .i_we   (mem_we),
      .i_addr (mem_addr),
      .i_sel  (mem_sel),
      .i_wdat (mem_wdat),
      .o_ack  (mem_ack),
      .o_rdat (mem_rdat)
   );

   always #10 i_clk = ~i_clk; // 20 ns period.

   // count rising edges of the memory request.
   always @(negedge i_clk) begin
      if (mem_req === 1'b1 && !mem_req_seen) mem_req_rises++;
      mem_req_seen = (mem_req === 1'b1);
   end

   // 45 commands of at most about 110 cycles each fit well inside the limit.
   always @(posedge i_clk) begin
      cycles++;
      if (cycles >= 8000) begin
         $display("timeout: the tests did not finish within %0d cycles", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   function automatic logic [15:0] next_rand();
      rand_q = rand_q * 32'd1103515245 + 32'd12345;
      return rand_q[31:16]; // low lcg bits are weak.
   endfunction

   function automatic logic [7:0] fill_byte(logic [7:0] a);
      return a * 8'd37 + 8'd11;
   endfunction

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
      $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, expected);
      value_errors++;
   endtask

   task automatic report_protocol(input string msg);
      $display("ERROR: %s", msg);
      proto_errors++;
   endtask

   // load result built from the shadow bytes, sign or zero extended.
   function automatic logic [31:0] expected_load(logic [7:0] a, lsu_pkg::lsu_size_e size,
                                                 logic sgn);
      case (size)
         lsu_pkg::SZ_BYTE: return {{24{sgn & shadow[a][7]}}, shadow[a]};
         lsu_pkg::SZ_HALF: return {{16{sgn & shadow[a + 8'd1][7]}}, shadow[a + 8'd1], shadow[a]};
         default:          return {shadow[a + 8'd3], shadow[a + 8'd2], shadow[a + 8'd1], shadow[a]};
      endcase
   endfunction

   function automatic void update_shadow(logic [7:0] a, lsu_pkg::lsu_size_e size,
                                         logic [31:0] w);
      shadow[a] = w[7:0];
      if (size != lsu_pkg::SZ_BYTE) shadow[a + 8'd1] = w[15:8];
      if (size == lsu_pkg::SZ_WORD) begin
         shadow[a + 8'd2] = w[23:16];
         shadow[a + 8'd3] = w[31:24];
      end
   endfunction

   task automatic compare_mem_word(input logic [7:0] a);
      logic [7:0]  base;
      logic [31:0] expected;
      base     = {a[7:2], 2'b00};
      expected = {shadow[base + 8'd3], shadow[base + 8'd2], shadow[base + 8'd1], shadow[base]};
      if (mem0.mem[a[7:2]] !== expected) begin
         report_value($sformatf("mem0.mem[%0d]", a[7:2]), mem0.mem[a[7:2]], expected);
      end
   endtask

   // one full four-phase command, requester release delayed by 0 to 2 cycles.
   task automatic do_cmd(input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_size_e size,
                         input logic sgn, input logic [31:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic mis);
      logic [1:0] hold;
      @(posedge i_clk);
      cmd_req    <= 1'b1;
      cmd_op     <= op;
      cmd_size   <= size;
      cmd_signed <= sgn;
      cmd_addr   <= addr;
      cmd_wdata  <= wdata;
      @(negedge i_clk);
      while (!cmd_ack) @(negedge i_clk);
      rdata = rsp_data;
      mis   = rsp_misalign;
      hold  = 2'(next_rand() % 16'd3);
      repeat (hold) begin
         @(negedge i_clk);
         if (!cmd_ack) report_protocol("o_cmd_ack fell while i_cmd_req was still high");
      end
      @(posedge i_clk);
      cmd_req <= 1'b0;
      @(negedge i_clk);
      if (!cmd_ack) report_protocol("o_cmd_ack fell before the unit could see i_cmd_req low");
      while (cmd_ack) @(negedge i_clk);
   endtask

   // runs a command and checks response, bus activity and memory against the shadow.
   task automatic run_checked_cmd(input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_size_e size,
                                  input logic sgn, input logic [31:0] addr,
                                  input logic [31:0] wdata, output logic [31:0] rdata);
      logic        mis;
      logic        exp_mis;
      logic [31:0] exp_data;
      int          rises_before;
      exp_mis  = (size == lsu_pkg::SZ_HALF && addr[0]) ||
                 (size == lsu_pkg::SZ_WORD && addr[1:0] != 2'b00);
      exp_data = (exp_mis || op == lsu_pkg::LSU_STORE) ? 32'h0 : expected_load(addr[7:0], size, sgn);
      rises_before = mem_req_rises;
      do_cmd(op, size, sgn, addr, wdata, rdata, mis);
      if (mis !== exp_mis) report_value("o_rsp_misalign", {31'h0, mis}, {31'h0, exp_mis});
      if (rdata !== exp_data) report_value("o_rsp_data", rdata, exp_data);
      if (exp_mis && mem_req_rises != rises_before) begin
         report_protocol("o_mem_req rose during a misaligned command");
      end
      if (!exp_mis && mem_req_rises != rises_before + 1) begin
         report_protocol("an aligned command did not run exactly one memory transaction");
      end
      if (!exp_mis && op == lsu_pkg::LSU_STORE) update_shadow(addr[7:0], size, wdata);
      compare_mem_word(addr[7:0]);
   endtask

   task automatic word_store_load();
      logic [31:0] a;
      logic [31:0] w;
      logic [31:0] rdata;
      for (int k = 0; k < 2; k++) begin
         a = (k != 0) ? 32'hfc : 32'h20;
         w = (k != 0) ? 32'h8000_7ffe : 32'hc0de_1234;
         run_checked_cmd(lsu_pkg::LSU_STORE, lsu_pkg::SZ_WORD, 1'b0, a, w, rdata);
         run_checked_cmd(lsu_pkg::LSU_LOAD, lsu_pkg::SZ_WORD, 1'b0, a, 32'h0, rdata);
         if (rdata !== w) report_value("o_rsp_data", rdata, w);
      end
   endtask

   // upper store bits are nonzero, only the low byte may land.
   task automatic byte_lane_stores();
      logic [31:0] rdata;
      for (int l = 0; l < 4; l++) begin
         run_checked_cmd(lsu_pkg::LSU_STORE, lsu_pkg::SZ_BYTE, 1'b0, 32'h40 + l,
                         32'h5a3c_e100 | (32'h81 + 32'h22 * l), rdata);
      end
   endtask

   // word 0x84 holds bytes 1f 44 69 8e, both sign cases per width.
   task automatic narrow_loads();
      logic [31:0] rdata;
      for (int s = 0; s < 2; s++) begin
         for (int l = 0; l < 4; l++) begin
            run_checked_cmd(lsu_pkg::LSU_LOAD, lsu_pkg::SZ_BYTE, s[0], 32'h84 + l, 32'h0, rdata);
         end
         run_checked_cmd(lsu_pkg::LSU_LOAD, lsu_pkg::SZ_HALF, s[0], 32'h84, 32'h0, rdata);
         run_checked_cmd(lsu_pkg::LSU_LOAD, lsu_pkg::SZ_HALF, s[0], 32'h86, 32'h0, rdata);
      end
   endtask

   task automatic misaligned_access();
      logic [31:0] rdata;
      run_checked_cmd(lsu_pkg::LSU_LOAD, lsu_pkg::SZ_HALF, 1'b1, 32'h51, 32'h0, rdata);
      run_checked_cmd(lsu_pkg::LSU_LOAD, lsu_pkg::SZ_WORD, 1'b0, 32'h62, 32'h0, rdata);
      run_checked_cmd(lsu_pkg::LSU_STORE, lsu_pkg::SZ_HALF, 1'b0, 32'h73, 32'hffff_ffff, rdata);
      run_checked_cmd(lsu_pkg::LSU_STORE, lsu_pkg::SZ_WORD, 1'b0, 32'h91, 32'h1234_5678, rdata);
      run_checked_cmd(lsu_pkg::LSU_STORE, lsu_pkg::SZ_WORD, 1'b0, 32'ha3, 32'hdead_0001, rdata);
   endtask

   task automatic random_mix();
      logic [15:0]        r;
      logic [15:0]        hi;
      logic [15:0]        lo;
      lsu_pkg::lsu_size_e size;
      logic [7:0]         a;
      logic [31:0]        rdata;
      for (int n = 0; n < 20; n++) begin
         r    = next_rand();
         hi   = next_rand();
         lo   = next_rand();
         size = (r[2:1] == 2'd0) ? lsu_pkg::SZ_BYTE :
                (r[2:1] == 2'd1) ? lsu_pkg::SZ_HALF : lsu_pkg::SZ_WORD;
         a    = r[11:4];
         if ((r[12] | r[13]) && size == lsu_pkg::SZ_HALF) a[0] = 1'b0; // mostly legal.
         if ((r[12] | r[13]) && size == lsu_pkg::SZ_WORD) a[1:0] = 2'b00;
         run_checked_cmd(r[0] ? lsu_pkg::LSU_STORE : lsu_pkg::LSU_LOAD, size, r[3],
                         {24'h0, a}, {hi, lo}, rdata);
      end
   endtask

   initial begin
      i_clk      = 1'b0;
      i_arst_n   = 1'b0;
      cmd_req    = 1'b0;
      cmd_op     = lsu_pkg::LSU_LOAD;
      cmd_size   = lsu_pkg::SZ_WORD;
      cmd_signed = 1'b0;
      cmd_addr   = 32'h0;
      cmd_wdata  = 32'h0;
      for (int a = 0; a < 256; a++) begin
         shadow[a] = fill_byte(8'(a)); // same start pattern as mem0.
      end
      repeat (16) @(posedge i_clk);
      i_arst_n <= 1'b1;
      word_store_load();
      byte_lane_stores();
      narrow_loads();
      misaligned_access();
      random_mix();
      $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: src.f
logic/lsu_pkg.sv
logic/lsu_serial_if.sv
logic/lsu_sequencer.sv
logic/lsu_data_shifter.sv
logic/lsu_bus_master.sv
logic/serial_lsu_top.sv
bench/mem_model.sv
bench/tb_serial_lsu.sv

// File: Makefile
TOP := tb_serial_lsu

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
